/* common/rv_consts.svh */
// rv32i core constants
// word width, register count, reset pc, base opcode values
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN     32          // data and address width
`define RV_NREGS    32          // x0..x31
`define RV_RESET_PC 32'h0000_0000

// opcode field, instr[6:0]
`define RV_OP_LOAD   7'b000_0011
`define RV_OP_STORE  7'b010_0011
`define RV_OP_BRANCH 7'b110_0011
`define RV_OP_JAL    7'b110_1111
`define RV_OP_JALR   7'b110_0111
`define RV_OP_LUI    7'b011_0111
`define RV_OP_AUIPC  7'b001_0111
`define RV_OP_IMM    7'b001_0011  // reg-imm alu ops
`define RV_OP_REG    7'b011_0011  // reg-reg alu ops

`endif

/* common/rv_pkg.sv */
// shared control types for the rv32i core
// alu function, writeback source, next pc source
`default_nettype none

package rv_pkg;

	// alu function, sub and sra folded in
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_t;

	// what lands in rd
	typedef enum logic [2:0] {
		RES_ALU    = 3'd0,  // alu result
		RES_LOAD   = 3'd1,  // extracted load data
		RES_PC4    = 3'd2,  // link value for jal/jalr
		RES_UIMM   = 3'd3,  // lui
		RES_PCUIMM = 3'd4   // auipc
	} result_src_t;

	// next pc choice
	typedef enum logic [1:0] {
		PC_SEQ    = 2'd0,   // pc + 4
		PC_JAL    = 2'd1,
		PC_JALR   = 2'd2,
		PC_BRANCH = 2'd3    // only if compare holds
	} pc_src_t;

endpackage : rv_pkg

`default_nettype wire

/* hdl/rv_controller.sv */
// main decoder and alu decoder
// opcode, funct3, funct7 to datapath control strobes
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_controller (
	input  logic [31:0]          instr,
	output logic                 regwrite,
	output logic                 alusrc,
	output logic                 memwrite,
	output rv_pkg::alu_op_t      alu_op,
	output rv_pkg::result_src_t  result_src,
	output rv_pkg::pc_src_t      pc_src
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_5;   // sub / sra select
	logic       alt_op;     // funct7 bit applies
	alu_op_t    alu_fn;     // alu decoder output

	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	assign funct7_5 = instr[30];

	// bit 30 picks sub and sra for reg-reg, only srai for reg-imm
	assign alt_op = funct7_5 &
		((opcode == `RV_OP_REG) | (funct3 == 3'b101));

	// alu decoder
	always_comb begin
		case (funct3)
			3'b000:  alu_fn = alt_op ? ALU_SUB : ALU_ADD;
			3'b001:  alu_fn = ALU_SLL;
			3'b010:  alu_fn = ALU_SLT;
			3'b011:  alu_fn = ALU_SLTU;
			3'b100:  alu_fn = ALU_XOR;
			3'b101:  alu_fn = alt_op ? ALU_SRA : ALU_SRL;
			3'b110:  alu_fn = ALU_OR;
			default: alu_fn = ALU_AND;  // 3'b111
		endcase
	end

	// main decoder
	always_comb begin
		regwrite   = 1'b0;  // unknown opcodes write nothing
		alusrc     = 1'b0;
		memwrite   = 1'b0;
		alu_op     = ALU_ADD;
		result_src = RES_ALU;
		pc_src     = PC_SEQ;
		case (opcode)
			`RV_OP_LOAD: begin
				regwrite   = 1'b1;
				alusrc     = 1'b1;      // base + itypeimm
				result_src = RES_LOAD;
			end
			`RV_OP_STORE: begin
				alusrc   = 1'b1;        // base + stypeimm
				memwrite = 1'b1;
			end
			`RV_OP_BRANCH: begin
				alu_op = ALU_SUB;       // compare itself lives in datapath
				pc_src = PC_BRANCH;
			end
			`RV_OP_JAL: begin
				regwrite   = 1'b1;
				result_src = RES_PC4;
				pc_src     = PC_JAL;
			end
			`RV_OP_JALR: begin
				regwrite   = 1'b1;
				alusrc     = 1'b1;
				result_src = RES_PC4;
				pc_src     = PC_JALR;
			end
			`RV_OP_LUI: begin
				regwrite   = 1'b1;
				result_src = RES_UIMM;
			end
			`RV_OP_AUIPC: begin
				regwrite   = 1'b1;
				result_src = RES_PCUIMM;
			end
			`RV_OP_IMM: begin
				regwrite = 1'b1;
				alusrc   = 1'b1;
				alu_op   = alu_fn;
			end
			`RV_OP_REG: begin
				regwrite = 1'b1;
				alu_op   = alu_fn;
			end
			default: ;
		endcase
	end

endmodule : rv_controller

`default_nettype wire

/* datapath/instn_decode.sv */
// instruction field slicing
// sign-extended immediates for i, s, b, u and j formats
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module instn_decode (
	input  logic [31:0]             instr,
	output logic [2:0]              funct3,
	output logic [4:0]              rs1,
	output logic [4:0]              rs2,
	output logic [4:0]              rd,
	output logic [`RV_XLEN-1:0]     itypeimm,
	output logic [`RV_XLEN-1:0]     stypeimm,
	output logic [`RV_XLEN-1:0]     branchimm,
	output logic [`RV_XLEN-1:0]     utypeimm,
	output logic [`RV_XLEN-1:0]     jumpimm
);

	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	// loads, jalr, reg-imm alu
	assign itypeimm  = {{20{instr[31]}}, instr[31:20]};
	// stores, split field
	assign stypeimm  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	// branch offset, bit 0 implied zero
	assign branchimm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign utypeimm  = {instr[31:12], 12'b0};   // lui / auipc
	// jal offset, +-1 MiB
	assign jumpimm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule : instn_decode

`default_nettype wire

/* datapath/regfile.sv */
// integer register file
// two async read ports, one clocked write port, x0 reads zero
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module regfile (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 we,
	input  logic [4:0]           rs1,
	input  logic [4:0]           rs2,
	input  logic [4:0]           rd,
	input  logic [`RV_XLEN-1:0]  wd,
	output logic [`RV_XLEN-1:0]  rs1_data,
	output logic [`RV_XLEN-1:0]  rs2_data
);

	// x0 has no storage
	logic [`RV_XLEN-1:0] rf [1:`RV_NREGS-1];

	always_ff @(posedge clk) begin
		if (we && reset && (rd != 5'd0))    // held off while in reset
			rf[rd] <= wd;
	end

	assign rs1_data = (rs1 != 5'd0) ? rf[rs1] : '0;
	assign rs2_data = (rs2 != 5'd0) ? rf[rs2] : '0;

	// write data comes through decode, alu and result mux
	a_wd_known: assert property (@(posedge clk) disable iff (!reset)
		(we && rd != 5'd0) |-> !$isunknown(wd))
		else $error("unknown write data to x%0d", rd);

endmodule : regfile

`default_nettype wire

/* datapath/alu.sv */
// rv32i alu
// add sub shifts compares and logic ops on two operands
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module alu (
	input  logic [`RV_XLEN-1:0]  srca,
	input  logic [`RV_XLEN-1:0]  srcb,
	input  rv_pkg::alu_op_t      alu_op,
	output logic [`RV_XLEN-1:0]  aluout
);
	import rv_pkg::*;

	logic [4:0] shamt;  // only low five bits shift

	assign shamt = srcb[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:  aluout = srca + srcb;
			ALU_SUB:  aluout = srca - srcb;
			ALU_SLL:  aluout = srca << shamt;
			ALU_SLT:  aluout = ($signed(srca) < $signed(srcb)) ? 32'd1 : 32'd0;
			ALU_SLTU: aluout = (srca < srcb) ? 32'd1 : 32'd0;
			ALU_XOR:  aluout = srca ^ srcb;
			ALU_SRL:  aluout = srca >> shamt;   // zero fill
			ALU_SRA:  aluout = $signed(srca) >>> shamt;  // sign fill
			ALU_OR:   aluout = srca | srcb;
			ALU_AND:  aluout = srca & srcb;
			default:  aluout = '0;
		endcase
	end

endmodule : alu

`default_nettype wire

/* datapath/datapath.sv */
// rv32i datapath
// pc and next pc, operand and result muxes, load extract, store merge, branch compare
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module datapath (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [31:0]          instr,
	input  logic [`RV_XLEN-1:0]  readdata,
	input  logic                 regwrite,
	input  logic                 alusrc,
	input  rv_pkg::alu_op_t      alu_op,
	input  rv_pkg::result_src_t  result_src,
	input  rv_pkg::pc_src_t      pc_src,
	output logic [`RV_XLEN-1:0]  pc,
	output logic [`RV_XLEN-1:0]  aluout,
	output logic [`RV_XLEN-1:0]  writedata
);
	import rv_pkg::*;

	logic [2:0]          funct3;
	logic [4:0]          rs1, rs2, rd;
	logic [`RV_XLEN-1:0] itypeimm, stypeimm, branchimm, utypeimm, jumpimm;
	logic [`RV_XLEN-1:0] rs1_data, rs2_data;
	logic [`RV_XLEN-1:0] srcb, imm;
	logic [`RV_XLEN-1:0] pcplus4, pc_next;
	logic [`RV_XLEN-1:0] result;
	logic [`RV_XLEN-1:0] lane_data;     // readdata shifted to lane 0
	logic [`RV_XLEN-1:0] load_data;
	logic [`RV_XLEN-1:0] st_mask, st_data;
	logic                is_store;
	logic                cond;          // branch comparison outcome

	instn_decode u_decode (
		.instr(instr), .funct3(funct3),
		.rs1(rs1), .rs2(rs2), .rd(rd),
		.itypeimm(itypeimm), .stypeimm(stypeimm), .branchimm(branchimm),
		.utypeimm(utypeimm), .jumpimm(jumpimm)
	);

	regfile u_rf (
		.clk(clk), .reset(reset), .we(regwrite),
		.rs1(rs1), .rs2(rs2), .rd(rd), .wd(result),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	// s-format immediate only for stores
	assign is_store = (instr[6:0] == `RV_OP_STORE);
	assign imm      = is_store ? stypeimm : itypeimm;
	assign srcb     = alusrc ? imm : rs2_data;

	alu u_alu (.srca(rs1_data), .srcb(srcb), .alu_op(alu_op), .aluout(aluout));

	// branch compare on register values, not alu
	always_comb begin
		case (funct3)
			3'b000:  cond = (rs1_data == rs2_data);                    // beq
			3'b001:  cond = (rs1_data != rs2_data);                    // bne
			3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));   // blt
			3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));  // bge
			3'b110:  cond = (rs1_data < rs2_data);                     // bltu
			3'b111:  cond = (rs1_data >= rs2_data);                    // bgeu
			default: cond = 1'b0;
		endcase
	end

	// next pc
	assign pcplus4 = pc + 32'd4;
	always_comb begin
		case (pc_src)
			PC_JAL:    pc_next = pc + jumpimm;
			PC_JALR:   pc_next = (rs1_data + itypeimm) & ~32'd1;   // clear bit 0
			PC_BRANCH: pc_next = cond ? (pc + branchimm) : pcplus4;
			default:   pc_next = pcplus4;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			pc <= `RV_RESET_PC;
		else
			pc <= pc_next;
	end

	// load extraction, little-endian lane from address bits 1:0
	assign lane_data = readdata >> {aluout[1:0], 3'b000};
	always_comb begin
		case (funct3)
			3'b000:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};    // lb
			3'b001:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};  // lh
			3'b100:  load_data = {24'b0, lane_data[7:0]};                 // lbu
			3'b101:  load_data = {16'b0, lane_data[15:0]};                // lhu
			default: load_data = readdata;                                // lw
		endcase
	end

	// store merge into the current word, memory always writes full words
	always_comb begin
		case (funct3[1:0])
			2'b00: begin    // sb
				st_mask = 32'h0000_00ff << {aluout[1:0], 3'b000};
				st_data = {4{rs2_data[7:0]}};
			end
			2'b01: begin    // sh
				st_mask = 32'h0000_ffff << {aluout[1], 4'b0000};
				st_data = {2{rs2_data[15:0]}};
			end
			default: begin  // sw
				st_mask = 32'hffff_ffff;
				st_data = rs2_data;
			end
		endcase
	end
	assign writedata = (readdata & ~st_mask) | (st_data & st_mask);

	// writeback select
	always_comb begin
		case (result_src)
			RES_LOAD:   result = load_data;
			RES_PC4:    result = pcplus4;
			RES_UIMM:   result = utypeimm;
			RES_PCUIMM: result = pc + utypeimm;
			default:    result = aluout;
		endcase
	end

	// every jump and branch target keeps word alignment
	a_pc_aligned: assert property (@(posedge clk) disable iff (!reset)
		pc[1:0] == 2'b00)
		else $error("misaligned pc %h", pc);

endmodule : datapath

`default_nettype wire

/* hdl/rv_core.sv */
// single-cycle rv32i core top
// controller plus datapath, memories sit outside
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_core (
	input  logic                 clk,
	input  logic                 reset,
	output logic [`RV_XLEN-1:0]  pc,        // instruction address
	input  logic [31:0]          instr,
	output logic [`RV_XLEN-1:0]  dataadr,   // alu result
	output logic [`RV_XLEN-1:0]  writedata, // merged full word
	input  logic [`RV_XLEN-1:0]  readdata,
	output logic                 memwrite
);
	import rv_pkg::*;

	logic        regwrite;
	logic        alusrc;
	alu_op_t     alu_op;
	result_src_t result_src;
	pc_src_t     pc_src;

	rv_controller u_ctrl (
		.instr(instr),
		.regwrite(regwrite), .alusrc(alusrc), .memwrite(memwrite),
		.alu_op(alu_op), .result_src(result_src), .pc_src(pc_src)
	);

	datapath u_dp (
		.clk(clk), .reset(reset),
		.instr(instr), .readdata(readdata),
		.regwrite(regwrite), .alusrc(alusrc),
		.alu_op(alu_op), .result_src(result_src), .pc_src(pc_src),
		.pc(pc), .aluout(dataadr), .writedata(writedata)
	);

endmodule : rv_core

`default_nettype wire

/* tb/tb_clock.sv */
// testbench clock and reset source
// 20 ns clock, active-low reset held for 8 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;     // 20 ns period
	end

	// released just after an edge, ahead of the stimulus delay
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b1;
	end

endmodule : tb_clock

`default_nettype wire

/* tb/rv_core_checker.sv */
// result checker for the rv32i core testbench
// memwrite, store address and data per row, next pc one cycle later
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] pc,
	input  logic        memwrite,
	input  logic [31:0] dataadr,
	input  logic [31:0] writedata,
	input  logic        row_valid,      // a table row is being executed
	input  logic        exp_memwrite,
	input  logic [31:0] exp_next_pc,
	input  logic [31:0] exp_dataadr,    // store rows only
	input  logic [31:0] exp_writedata,
	output int          errors
);

	logic        pc_due;        // next pc check owed by the previous row
	logic [31:0] pc_expected;

	task automatic report(input string name, input logic [31:0] exp, act);
		$display("Error at %0d ns: %s expected %h, actual %h", $time, name, exp, act);
		errors++;
	endtask

	initial begin
		errors = 0;
		pc_due = 1'b0;
		pc_expected = '0;
	end

	// mid-cycle, inputs settled since posedge + 2 ns
	always @(negedge clk) begin
		if (pc_due && pc !== pc_expected)
			report("pc", pc_expected, pc);
		pc_due = 1'b0;
		if (!reset) begin
			if (memwrite !== 1'b0)      // nop in reset, no store allowed
				report("memwrite", 32'd0, {31'd0, memwrite});
		end else if (row_valid) begin
			if (memwrite !== exp_memwrite)
				report("memwrite", {31'd0, exp_memwrite}, {31'd0, memwrite});
			if (exp_memwrite) begin
				if (dataadr !== exp_dataadr)
					report("dataadr", exp_dataadr, dataadr);
				if (writedata !== exp_writedata)    // full merged word
					report("writedata", exp_writedata, writedata);
			end
			pc_expected = exp_next_pc;  // checked after the coming edge
			pc_due = 1'b1;
		end
	end

endmodule : rv_core_checker

`default_nettype wire

/* tb/rv_core_tb.sv */
// rv32i core testbench top
// instruction table with expected results, table-driven memories, uut and checker
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_core_tb;

	localparam int          MAX_CYCLES = 200;
	localparam logic [31:0] NOP  = 32'h0000_0013;  // addi x0, x0, 0
	localparam logic [31:0] BASE = 32'h0001_0000;  // x31 after lui
	localparam logic [31:0] FILL = 32'ha5a5_5a5a;  // old word under a sw
	localparam logic [31:0] WORD = 32'h817f_36c4;  // load source, mixed lane signs
	localparam logic [31:0] OLD  = 32'h1122_3344;  // word under sb / sh

	typedef struct packed {
		logic [31:0] ins;
		logic [31:0] data;      // returned as readdata
		logic [31:0] next_pc;
		logic        mw;
		logic [31:0] adr;       // stores only
		logic [31:0] wd;
		logic        hole;      // skipped by a taken branch or jump
	} row_t;

	row_t table_q[$];

	logic        clk;
	logic        reset;
	logic [31:0] pc, instr, dataadr, writedata, readdata;
	logic        memwrite;
	logic        row_valid;
	logic        exp_memwrite;
	logic [31:0] exp_next_pc, exp_dataadr, exp_writedata;
	int          check_errors;
	int          run_errors;

	tb_clock clock_gen (.clk(clk), .reset(reset));

	rv_core uut (
		.clk(clk), .reset(reset),
		.pc(pc), .instr(instr),
		.dataadr(dataadr), .writedata(writedata),
		.readdata(readdata), .memwrite(memwrite)
	);

	rv_core_checker u_check (
		.clk(clk), .reset(reset),
		.pc(pc), .memwrite(memwrite), .dataadr(dataadr), .writedata(writedata),
		.row_valid(row_valid), .exp_memwrite(exp_memwrite), .exp_next_pc(exp_next_pc),
		.exp_dataadr(exp_dataadr), .exp_writedata(exp_writedata),
		.errors(check_errors)
	);

	// instruction encoders, field order per the rv32i formats
	function automatic logic [31:0] itype(input int op, f3, rd, rs1, imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] rtype(input int f7, f3, rd, rs1, rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OP_REG};
	endfunction

	function automatic logic [31:0] stype(input int f3, rs2, rs1, imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic logic [31:0] btype(input int f3, rs1, rs2, imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			`RV_OP_BRANCH};
	endfunction

	function automatic logic [31:0] utype(input int op, rd, imm);
		return {imm[19:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] jtype(input int rd, imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OP_JAL};
	endfunction

	function automatic logic [31:0] this_pc();
		return 32'(table_q.size() * 4);     // row index times 4
	endfunction

	task automatic table_row(input logic [31:0] ins, data, next_pc,
		input logic mw, input logic [31:0] adr, wd, input logic hole);
		table_q.push_back(row_t'{ins, data, next_pc, mw, adr, wd, hole});
	endtask

	task automatic plain_row(input logic [31:0] ins);
		table_row(ins, '0, this_pc() + 4, 1'b0, '0, '0, 1'b0);
	endtask

	task automatic load_row(input logic [31:0] ins, data);
		table_row(ins, data, this_pc() + 4, 1'b0, '0, '0, 1'b0);
	endtask

	task automatic store_row(input logic [31:0] ins, data, adr, wd);
		table_row(ins, data, this_pc() + 4, 1'b1, adr, wd, 1'b0);
	endtask

	task automatic jump_row(input logic [31:0] ins, next_pc);
		table_row(ins, '0, next_pc, 1'b0, '0, '0, 1'b0);
	endtask

	task automatic hole_row();
		table_row(NOP, '0, this_pc() + 4, 1'b0, '0, '0, 1'b1);
	endtask

	task automatic store_x20(input logic [31:0] wd);   // sw x20, 64(x31)
		store_row(stype(2, 20, 31, 64), '0, BASE + 64, wd);
	endtask

	task automatic build_table();
		plain_row(itype(`RV_OP_IMM, 0, 1, 0, 100));             // 00 x1 = 100
		plain_row(itype(`RV_OP_IMM, 0, 2, 0, -7));              // 04 x2 = -7
		plain_row(utype(`RV_OP_LUI, 31, 'h10));                 // 08 x31 = base
		plain_row(rtype(0, 0, 3, 1, 2));                        // 0c add
		store_row(stype(2, 3, 31, 0), FILL, BASE + 0, 32'h0000_005d);
		plain_row(rtype('h20, 0, 4, 2, 1));                     // 14 sub
		store_row(stype(2, 4, 31, 4), FILL, BASE + 4, 32'hffff_ff95);
		plain_row(rtype(0, 2, 5, 2, 1));                        // 1c slt, -7 < 100
		plain_row(rtype(0, 3, 6, 2, 1));                        // 20 sltu, huge < 100
		store_row(stype(2, 5, 31, 8), FILL, BASE + 8, 32'h0000_0001);
		store_row(stype(2, 6, 31, 12), FILL, BASE + 12, 32'h0000_0000);
		plain_row(rtype(0, 4, 7, 1, 2));                        // 2c xor
		store_row(stype(2, 7, 31, 16), FILL, BASE + 16, 32'hffff_ff9d);
		plain_row(rtype(0, 6, 8, 1, 2));                        // 34 or
		plain_row(rtype(0, 7, 9, 1, 2));                        // 38 and
		store_row(stype(2, 8, 31, 20), FILL, BASE + 20, 32'hffff_fffd);
		store_row(stype(2, 9, 31, 24), FILL, BASE + 24, 32'h0000_0060);
		plain_row(itype(`RV_OP_IMM, 0, 10, 0, 4));              // 44 shift amount
		plain_row(rtype(0, 1, 11, 2, 10));                      // 48 sll
		plain_row(rtype(0, 5, 12, 2, 10));                      // 4c srl
		plain_row(rtype('h20, 5, 13, 2, 10));                   // 50 sra
		store_row(stype(2, 11, 31, 28), FILL, BASE + 28, 32'hffff_ff90);
		store_row(stype(2, 12, 31, 32), FILL, BASE + 32, 32'h0fff_ffff);
		store_row(stype(2, 13, 31, 36), FILL, BASE + 36, 32'hffff_ffff);
		plain_row(itype(`RV_OP_IMM, 5, 14, 2, 'h401));          // 60 srai by 1
		store_row(stype(2, 14, 31, 40), FILL, BASE + 40, 32'hffff_fffc);
		// upper immediates, x0 stays zero
		plain_row(utype(`RV_OP_LUI, 15, 'habcde));              // 68
		store_row(stype(2, 15, 31, 44), FILL, BASE + 44, 32'habcd_e000);
		plain_row(utype(`RV_OP_AUIPC, 16, 1));                  // 70, pc + 0x1000
		store_row(stype(2, 16, 31, 48), FILL, BASE + 48, 32'h0000_1070);
		plain_row(itype(`RV_OP_IMM, 0, 0, 0, 55));              // 78 write to x0
		store_row(stype(2, 0, 31, 52), FILL, BASE + 52, 32'h0000_0000);
		// branches, not taken then taken over a hole
		jump_row(btype(0, 1, 2, 8), 32'h84);                    // 80 beq
		jump_row(btype(0, 1, 1, 8), 32'h8c);
		hole_row();
		jump_row(btype(1, 1, 1, 8), 32'h90);                    // 8c bne
		jump_row(btype(1, 1, 2, 8), 32'h98);
		hole_row();
		jump_row(btype(4, 1, 2, 8), 32'h9c);                    // 98 blt
		jump_row(btype(4, 2, 1, 8), 32'ha4);
		hole_row();
		jump_row(btype(5, 2, 1, 8), 32'ha8);                    // a4 bge
		jump_row(btype(5, 1, 2, 8), 32'hb0);
		hole_row();
		jump_row(btype(6, 2, 1, 8), 32'hb4);                    // b0 bltu
		jump_row(btype(6, 1, 2, 8), 32'hbc);
		hole_row();
		jump_row(btype(7, 1, 2, 8), 32'hc0);                    // bc bgeu
		jump_row(btype(7, 2, 1, 8), 32'hc8);
		hole_row();
		// jumps, link value stored afterwards
		jump_row(jtype(17, 8), 32'hd0);                         // c8 jal x17
		hole_row();
		store_row(stype(2, 17, 31, 56), FILL, BASE + 56, 32'h0000_00cc);
		plain_row(itype(`RV_OP_IMM, 0, 18, 0, 'hde));           // d4
		jump_row(itype(`RV_OP_JALR, 0, 19, 18, 3), 32'he0);     // d8, 0xe1 -> 0xe0
		hole_row();
		store_row(stype(2, 19, 31, 60), FILL, BASE + 60, 32'h0000_00dc);
		// loads from WORD at every lane, then stored
		load_row(itype(`RV_OP_LOAD, 0, 20, 31, 0), WORD);       // e4 lb
		store_x20(32'hffff_ffc4);
		load_row(itype(`RV_OP_LOAD, 0, 20, 31, 1), WORD);
		store_x20(32'h0000_0036);
		load_row(itype(`RV_OP_LOAD, 0, 20, 31, 2), WORD);
		store_x20(32'h0000_007f);
		load_row(itype(`RV_OP_LOAD, 0, 20, 31, 3), WORD);
		store_x20(32'hffff_ff81);
		load_row(itype(`RV_OP_LOAD, 4, 20, 31, 0), WORD);       // lbu
		store_x20(32'h0000_00c4);
		load_row(itype(`RV_OP_LOAD, 4, 20, 31, 1), WORD);
		store_x20(32'h0000_0036);
		load_row(itype(`RV_OP_LOAD, 4, 20, 31, 2), WORD);
		store_x20(32'h0000_007f);
		load_row(itype(`RV_OP_LOAD, 4, 20, 31, 3), WORD);
		store_x20(32'h0000_0081);
		load_row(itype(`RV_OP_LOAD, 1, 20, 31, 0), WORD);       // lh
		store_x20(32'h0000_36c4);
		load_row(itype(`RV_OP_LOAD, 1, 20, 31, 2), WORD);
		store_x20(32'hffff_817f);
		load_row(itype(`RV_OP_LOAD, 5, 20, 31, 0), WORD);       // lhu
		store_x20(32'h0000_36c4);
		load_row(itype(`RV_OP_LOAD, 5, 20, 31, 2), WORD);
		store_x20(32'h0000_817f);
		load_row(itype(`RV_OP_LOAD, 2, 20, 31, 0), WORD);       // lw
		store_x20(32'h817f_36c4);
		// sb / sh of x4, only the addressed lane of OLD changes
		store_row(stype(0, 4, 31, 0), OLD, BASE + 0, 32'h1122_3395);
		store_row(stype(0, 4, 31, 1), OLD, BASE + 1, 32'h1122_9544);
		store_row(stype(0, 4, 31, 2), OLD, BASE + 2, 32'h1195_3344);
		store_row(stype(0, 4, 31, 3), OLD, BASE + 3, 32'h9522_3344);
		store_row(stype(1, 4, 31, 0), OLD, BASE + 0, 32'h1122_ff95);
		store_row(stype(1, 4, 31, 2), OLD, BASE + 2, 32'hff95_3344);
		jump_row(jtype(0, 0), this_pc());                       // jal x0, 0 ends it
	endtask

	initial begin : run
		int   cycles;
		int   idx;
		bit   done;
		row_t r;
		instr = NOP;                // keeps memwrite low in reset
		readdata = '0;
		row_valid = 1'b0;
		exp_memwrite = 1'b0;
		exp_next_pc = '0;
		exp_dataadr = '0;
		exp_writedata = '0;
		run_errors = 0;
		cycles = 0;
		done = 1'b0;
		build_table();
		while (!done && cycles < MAX_CYCLES) begin
			@(posedge clk);
			#2;
			cycles++;
			if (!reset) begin
				instr = NOP;
				readdata = '0;
			end else if ($isunknown(pc) || pc[1:0] != 2'b00 ||
				(pc >> 2) >= table_q.size()) begin
				$display("pc %h is outside the instruction table", pc);
				run_errors++;
				row_valid = 1'b0;
				done = 1'b1;
			end else begin
				idx = int'(pc >> 2);
				r = table_q[idx];
				if (r.hole) begin
					$display("instruction at pc %h should have been skipped", pc);
					run_errors++;
					row_valid = 1'b0;
					done = 1'b1;
				end else begin
					instr = r.ins;          // instruction memory
					readdata = r.data;      // data memory word at dataadr
					exp_next_pc = r.next_pc;
					exp_memwrite = r.mw;
					exp_dataadr = r.adr;
					exp_writedata = r.wd;
					row_valid = 1'b1;
					if (idx == table_q.size() - 1)
						done = 1'b1;
				end
			end
		end
		if (!done) begin
			$display("final instruction not reached within %0d cycles", MAX_CYCLES);
			run_errors++;
		end else begin
			repeat (2) @(negedge clk);  // let the next pc check of the last row run
		end
		#1;
		$display("check errors: %0d, run errors: %0d", check_errors, run_errors);
		if (check_errors == 0 && run_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule : rv_core_tb

`default_nettype wire

/* all.f */
+incdir+common
common/rv_pkg.sv
hdl/rv_controller.sv
datapath/instn_decode.sv
datapath/regfile.sv
datapath/alu.sv
datapath/datapath.sv
hdl/rv_core.sv
tb/tb_clock.sv
tb/rv_core_checker.sv
tb/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pkg.sv
      - hdl/rv_controller.sv
      - datapath/instn_decode.sv
      - datapath/regfile.sv
      - datapath/alu.sv
      - datapath/datapath.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_clock.sv
      - tb/rv_core_checker.sv
      - tb/rv_core_tb.sv
